// File: all.f
icache_pkg.sv
icache_if.sv
cache_line_store.sv
cache_lookup_lane.sv
icache_miss_ctrl.sv
icache_top.sv
tb_memory_model.sv
icache_tb.sv

// File: Makefile
# Verilator build and run for the instruction cache testbench

VERILATOR       ?= verilator
TOP             ?= icache_tb
FILELIST        ?= all.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert
EXTRA_FLAGS     ?=

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VERILATOR_FLAGS) $(EXTRA_FLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the binary exits nonzero when the testbench stops with $fatal
run: compile
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)

// File: icache_tb.sv
`timescale 1ns/10ps

module icache_tb import icache_pkg::*; ();

    localparam int lane_count   = 2;
    localparam int mem_latency  = 6;
    localparam int test_count   = 6;
    localparam int cycle_budget = 300;      // per test, for the watchdog
    localparam int valid_limit  = 100;      // cycles a fetch may take to turn valid
    localparam logic [31:0] cold_addr = 32'h0000_1234;

    logic                                  clock;
    logic                                  reset;
    logic [lane_count-1:0][addr_width-1:0] fetch_addr;
    logic [lane_count-1:0]                 fetch_en;
    logic [lane_count-1:0][line_width-1:0] fetch_data;
    logic [lane_count-1:0]                 fetch_valid;
    bus_command_t                          mem_command;
    logic [addr_width-1:0]                 mem_addr;
    logic [mem_tag_width-1:0]              mem_response;
    logic [mem_tag_width-1:0]              mem_tag;
    logic [line_width-1:0]                 mem_data;
    logic                                  reject_load;
    logic [7:0]                            reject_count;

    logic [15:0]              lfsr_state = 16'd26;
    logic                     bus_waiting = 1'b0;   // one load outstanding on the bus
    logic [mem_tag_width-1:0] bus_wait_tag;
    logic [addr_width-1:0]    load_addrs[$];        // every load presented
    logic [addr_width-1:0]    accepted_addrs[$];

    icache_top #(
        .lanes (lane_count)
    ) dut_i (
        .clock        (clock),
        .reset        (reset),
        .fetch_addr   (fetch_addr),
        .fetch_en     (fetch_en),
        .fetch_data   (fetch_data),
        .fetch_valid  (fetch_valid),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_data     (mem_data)
    );

    tb_memory_model #(
        .latency (mem_latency)
    ) mem_i (
        .clock        (clock),
        .reset        (reset),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_data     (mem_data),
        .reject_load  (reject_load),
        .reject_count (reject_count)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        repeat (cycle_budget * test_count) @(posedge clock);
        $display("timeout: the tests did not finish within %0d cycles",
                 cycle_budget * test_count);
        $display("Test FAILED");
        $fatal(1);
    end

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [31:0] line_of(input logic [31:0] addr);
        return {addr[31:3], 3'b000};
    endfunction

    // memory data is the line address and its inverse
    function automatic logic [63:0] expected_line(input logic [31:0] addr);
        logic [31:0] base;
        base = line_of(addr);
        return {base, ~base};
    endfunction

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        assert (expected === actual) else begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // one call per cycle, after the inputs have settled
    task automatic observe_bus(input string name);
        if (bus_waiting) begin
            compare_value({name, " command while waiting"}, 64'(bus_none), 64'(mem_command));
        end
        if (mem_command == bus_load) begin
            load_addrs.push_back(mem_addr);
            if (mem_response != '0) begin
                accepted_addrs.push_back(mem_addr);
                bus_waiting  = 1'b1;
                bus_wait_tag = mem_response;
            end
        end else if (bus_waiting && mem_tag == bus_wait_tag) begin
            bus_waiting = 1'b0;     // line is written at the coming edge
        end
    endtask

    task automatic settle(input string name);
        #10;
        observe_bus(name);
    endtask

    task automatic clear_bus_log();
        load_addrs.delete();
        accepted_addrs.delete();
    endtask

    task automatic fetch_until_valid(input logic [lane_count-1:0] mask, input string name);
        logic done;
        done = 1'b0;
        for (int cycles = 0; cycles < valid_limit && !done; cycles++) begin
            if (cycles != 0) begin
                @(negedge clock);
            end
            settle(name);
            done = ((fetch_valid & mask) == mask);
        end
        require(done, {name, ": fetch_valid never rose on the enabled lanes"});
    endtask

    // single lane fetch until valid, then the data check
    task automatic fetch_line(input int lane, input logic [31:0] addr, input string name);
        logic [lane_count-1:0] mask;
        mask       = '0;
        mask[lane] = 1'b1;
        clear_bus_log();
        @(negedge clock);
        reject_load      = 1'b0;
        fetch_en         = mask;
        fetch_addr[lane] = addr;
        fetch_until_valid(mask, name);
        compare_value(name, expected_line(addr), fetch_data[lane]);
    endtask

    task automatic idle_after_reset();
        @(negedge clock);
        fetch_en     = '0;
        reject_count = 8'(lane_count);  // one reject per lane below
        reject_load  = 1'b1;
        settle("idle_after_reset");
        compare_value("idle_after_reset", 64'(bus_none), 64'(mem_command));
        compare_value("idle_after_reset", 64'd0, 64'(fetch_valid));
        for (int i = 0; i < lane_count; i++) begin
            @(negedge clock);
            reject_load   = 1'b0;
            fetch_en      = '0;
            fetch_en[i]   = 1'b1;
            fetch_addr[i] = 32'h0000_5500;
            settle("idle_after_reset");
            compare_value("idle_after_reset", 64'd0, 64'(fetch_valid));
            compare_value("idle_after_reset", 64'(bus_load), 64'(mem_command));
        end
        @(negedge clock);
        fetch_en = '0;
        settle("idle_after_reset");
        require(!bus_waiting, "idle_after_reset: a rejected load was taken by the memory");
    endtask

    task automatic cold_miss();
        fetch_line(0, cold_addr, "cold_miss");
        compare_value("cold_miss", 64'd1, 64'(accepted_addrs.size()));
        compare_value("cold_miss", 64'(line_of(cold_addr)), 64'(accepted_addrs[0]));
    endtask

    task automatic repeat_hit();
        for (int i = 0; i < lane_count; i++) begin
            @(negedge clock);
            fetch_en      = '0;
            fetch_en[i]   = 1'b1;
            fetch_addr[i] = cold_addr ^ 32'h4;      // other word, same line
            settle("repeat_hit");
            require(fetch_valid[i], $sformatf("repeat_hit: lane %0d missed a filled line", i));
            compare_value("repeat_hit", 64'(bus_none), 64'(mem_command));
            compare_value("repeat_hit", expected_line(cold_addr), fetch_data[i]);
        end
    endtask

    task automatic multi_lane_miss();
        clear_bus_log();
        @(negedge clock);
        for (int i = 0; i < lane_count; i++) begin
            fetch_addr[i] = 32'h0000_2000 + 32'h0000_1048 * i;   // distinct index per lane
        end
        fetch_en = '1;
        fetch_until_valid('1, "multi_lane_miss");
        compare_value("multi_lane_miss", 64'(lane_count), 64'(accepted_addrs.size()));
        for (int i = 0; i < lane_count; i++) begin
            compare_value("multi_lane_miss", 64'(line_of(fetch_addr[i])), 64'(accepted_addrs[i]));
            compare_value("multi_lane_miss", expected_line(fetch_addr[i]), fetch_data[i]);
        end
    endtask

    task automatic rejected_load();
        logic [31:0] addr;
        addr = 32'h0000_40F0;
        @(negedge clock);
        fetch_en     = '0;
        reject_count = 8'd3;
        reject_load  = 1'b1;
        settle("rejected_load");
        fetch_line(0, addr, "rejected_load");
        compare_value("rejected_load", 64'd4, 64'(load_addrs.size()));
        compare_value("rejected_load", 64'd1, 64'(accepted_addrs.size()));
        foreach (load_addrs[i]) begin
            compare_value("rejected_load", 64'(line_of(addr)), 64'(load_addrs[i]));
        end
    endtask

    task automatic conflict_eviction();
        logic [31:0] rnd;
        logic [4:0]  index;
        logic [7:0]  tag_a;
        logic [7:0]  tag_b;
        rnd   = lfsr_bits(5);
        index = rnd[4:0];
        rnd   = lfsr_bits(8);
        tag_a = rnd[7:0];
        rnd   = lfsr_bits(8);
        tag_b = rnd[7:0];
        if (tag_b == tag_a) begin
            tag_b = ~tag_a;
        end
        fetch_line(0, {16'h0, tag_a, index, 3'b000}, "conflict_eviction");
        fetch_line(0, {16'h0, tag_b, index, 3'b000}, "conflict_eviction");
        compare_value("conflict_eviction", 64'd1, 64'(accepted_addrs.size()));
        // first line was replaced, so it has to come from memory again
        fetch_line(lane_count - 1, {16'h0, tag_a, index, 3'b000}, "conflict_eviction");
        compare_value("conflict_eviction", 64'd1, 64'(accepted_addrs.size()));
        compare_value("conflict_eviction", 64'({16'h0, tag_a, index, 3'b000}),
                      64'(accepted_addrs[0]));
    endtask

    initial begin
        reset        = 1'b1;
        fetch_en     = '0;
        fetch_addr   = '0;
        reject_load  = 1'b0;
        reject_count = '0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        idle_after_reset();
        cold_miss();
        repeat_hit();
        multi_lane_miss();
        rejected_load();
        conflict_eviction();
        $display("Test OK");
        $finish;
    end

endmodule

// File: tb_memory_model.sv
`timescale 1ns/10ps

module tb_memory_model import icache_pkg::*; #(
    parameter int latency = 6              // accept edge to completion tag
) (
    input  logic                     clock,
    input  logic                     reset,
    input  bus_command_t             mem_command,
    input  logic [addr_width-1:0]    mem_addr,
    output logic [mem_tag_width-1:0] mem_response,
    output logic [mem_tag_width-1:0] mem_tag,
    output logic [line_width-1:0]    mem_data,
    input  logic                     reject_load,   // reload the reject counter
    input  logic [7:0]               reject_count
);

    logic [mem_tag_width-1:0] next_tag;    // cycles 1 to 15, zero is never handed out
    logic [mem_tag_width-1:0] pend_tag;
    logic [addr_width-1:0]    pend_addr;
    logic [7:0]               rejects_left;
    logic                     accept;
    int                       countdown;

    assign accept       = (mem_command == bus_load) && (rejects_left == 8'd0);
    assign mem_response = accept ? next_tag : '0;    // answered in the request cycle

    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag     <= 4'd1;
            pend_tag     <= '0;
            pend_addr    <= '0;
            rejects_left <= 8'd0;
            countdown    <= 0;
            mem_tag      <= '0;
            mem_data     <= '0;
        end else begin
            mem_tag <= '0;                  // completion shows for one cycle only
            if (reject_load) begin
                rejects_left <= reject_count;
            end else if (mem_command == bus_load && rejects_left != 8'd0) begin
                rejects_left <= rejects_left - 8'd1;
            end
            if (accept) begin
                pend_addr <= mem_addr;
                pend_tag  <= next_tag;
                countdown <= latency;
                next_tag  <= (next_tag == '1) ? 4'd1 : next_tag + 4'd1;
            end else if (countdown == 1) begin
                // line address followed by its inverse
                mem_tag   <= pend_tag;
                mem_data  <= {pend_addr, ~pend_addr};
                countdown <= 0;
            end else if (countdown != 0) begin
                countdown <= countdown - 1;
            end
        end
    end

endmodule

// File: icache_top.sv
`timescale 1ns/10ps

module icache_top import icache_pkg::*; #(
    parameter int lanes = icache_pkg::lanes
) (
    input  logic                             clock,
    input  logic                             reset,

    // fetch lanes
    input  logic [lanes-1:0][addr_width-1:0] fetch_addr,
    input  logic [lanes-1:0]                 fetch_en,
    output logic [lanes-1:0][line_width-1:0] fetch_data,
    output logic [lanes-1:0]                 fetch_valid,

    // tagged memory bus
    output bus_command_t                     mem_command,
    output logic [addr_width-1:0]            mem_addr,
    input  logic [mem_tag_width-1:0]         mem_response,
    input  logic [mem_tag_width-1:0]         mem_tag,
    input  logic [line_width-1:0]            mem_data
);

    // lane to miss controller
    logic [lanes-1:0]                 lane_miss;
    logic [lanes-1:0][addr_width-1:0] lane_line_addr;

    cache_read_if rd_port [lanes] ();   // one read port per lane
    cache_fill_if fill_port ();

    cache_line_store #(
        .lanes (lanes)
    ) store_i (
        .clock (clock),
        .reset (reset),
        .rd    (rd_port),
        .fill  (fill_port)
    );

    // identical lookup lanes
    for (genvar g = 0; g < lanes; g++) begin : lane_g
        cache_lookup_lane lane_i (
            .fetch_addr  (fetch_addr[g]),
            .fetch_en    (fetch_en[g]),
            .rd          (rd_port[g]),
            .fetch_data  (fetch_data[g]),
            .fetch_valid (fetch_valid[g]),
            .miss        (lane_miss[g]),
            .line_addr   (lane_line_addr[g])
        );
    end

    icache_miss_ctrl #(
        .lanes (lanes)
    ) miss_ctrl_i (
        .clock          (clock),
        .reset          (reset),
        .lane_miss      (lane_miss),
        .lane_line_addr (lane_line_addr),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_response   (mem_response),
        .mem_tag        (mem_tag),
        .mem_data       (mem_data),
        .fill           (fill_port)
    );

endmodule

// File: icache_miss_ctrl.sv
`timescale 1ns/10ps

module icache_miss_ctrl import icache_pkg::*; #(
    parameter int lanes = icache_pkg::lanes
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [lanes-1:0]                lane_miss,
    input  logic [lanes-1:0][addr_width-1:0] lane_line_addr,
    output bus_command_t                    mem_command,
    output logic [addr_width-1:0]           mem_addr,
    input  logic [mem_tag_width-1:0]        mem_response,
    input  logic [mem_tag_width-1:0]        mem_tag,
    input  logic [line_width-1:0]           mem_data,
    cache_fill_if.ctrl                      fill
);

    typedef enum logic {
        ctrl_idle,      // free to issue a load
        ctrl_wait       // one load outstanding
    } ctrl_state_t;

    ctrl_state_t                state;
    logic [mem_tag_width-1:0]   out_tag;    // transaction tag of the outstanding load
    logic [index_width-1:0]     req_index;
    logic [cache_tag_width-1:0] req_tag;

    logic                       sel_valid;
    logic [addr_width-1:0]      sel_addr;
    logic                       issue;
    logic                       accepted;
    logic                       complete;

    // lowest numbered missing lane wins
    always_comb begin
        sel_valid = 1'b0;
        sel_addr  = '0;
        for (int i = lanes - 1; i >= 0; i--) begin
            if (lane_miss[i]) begin
                sel_valid = 1'b1;
                sel_addr  = lane_line_addr[i];
            end
        end
    end

    assign issue    = sel_valid && (state == ctrl_idle);
    assign accepted = issue && (mem_response != '0);     // zero response is a reject
    assign complete = (state == ctrl_wait) && (out_tag != '0) && (mem_tag == out_tag);

    // request goes out in the same cycle as the miss
    always_comb begin
        mem_command = bus_none;
        mem_addr    = '0;
        if (issue) begin
            mem_command = bus_load;
            mem_addr    = sel_addr;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= ctrl_idle;
            out_tag <= '0;
        end else if (complete) begin
            state   <= ctrl_idle;
            out_tag <= '0;
        end else if (accepted) begin
            state   <= ctrl_wait;
            out_tag <= mem_response;
        end
        // a rejected load leaves everything as is, retried next cycle
    end

    // line location of the outstanding load
    always_ff @(posedge clock) begin
        if (accepted) begin
            req_index <= sel_addr[offset_width +: index_width];
            req_tag   <= sel_addr[offset_width + index_width +: cache_tag_width];
        end
    end

    // returned line is written on the completion edge
    assign fill.wr_en    = complete;
    assign fill.wr_index = req_index;
    assign fill.wr_tag   = req_tag;
    assign fill.wr_data  = mem_data;

endmodule

// File: cache_lookup_lane.sv
`timescale 1ns/10ps

module cache_lookup_lane import icache_pkg::*; (
    input  logic [addr_width-1:0] fetch_addr,
    input  logic                  fetch_en,
    cache_read_if.lane            rd,
    output logic [line_width-1:0] fetch_data,
    output logic                  fetch_valid,
    output logic                  miss,
    output logic [addr_width-1:0] line_addr
);

    logic [index_width-1:0]     fetch_index;
    logic [cache_tag_width-1:0] fetch_tag;
    logic                       hit;

    // split the address into index and tag
    assign fetch_index = fetch_addr[offset_width +: index_width];
    assign fetch_tag   = fetch_addr[offset_width + index_width +: cache_tag_width];

    assign rd.rd_index = fetch_index;

    // tag compare against the stored entry
    assign hit = rd.rd_valid && (rd.rd_tag == fetch_tag);

    assign fetch_valid = fetch_en && hit;
    assign miss        = fetch_en && !hit;     // held until the fill lands
    assign fetch_data  = rd.rd_data;           // only meaningful with fetch_valid

    // line aligned request address for the miss controller
    assign line_addr = {fetch_addr[addr_width-1:offset_width], {offset_width{1'b0}}};

endmodule

// File: cache_line_store.sv
`timescale 1ns/10ps

module cache_line_store import icache_pkg::*; #(
    parameter int lanes = icache_pkg::lanes
) (
    input  logic         clock,
    input  logic         reset,
    cache_read_if.store  rd [lanes],
    cache_fill_if.store  fill
);

    // per line state
    logic [line_count-1:0]      valid_bits;
    logic [cache_tag_width-1:0] tag_mem  [line_count];
    logic [line_width-1:0]      data_mem [line_count];

    // valid bits are the only control state in the array
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (fill.wr_en) begin
            valid_bits[fill.wr_index] <= 1'b1;
        end
    end

    // tag and data follow the fill port
    always_ff @(posedge clock) begin
        if (fill.wr_en) begin
            tag_mem[fill.wr_index]  <= fill.wr_tag;
            data_mem[fill.wr_index] <= fill.wr_data;
        end
    end

    // every lane reads its own entry in parallel
    for (genvar g = 0; g < lanes; g++) begin : read_port_g
        assign rd[g].rd_valid = valid_bits[rd[g].rd_index];
        assign rd[g].rd_tag   = tag_mem[rd[g].rd_index];
        assign rd[g].rd_data  = data_mem[rd[g].rd_index];   // no bypass of a same-cycle fill
    end

endmodule

// File: icache_if.sv
`timescale 1ns/10ps

// combinational read port, one per fetch lane
interface cache_read_if import icache_pkg::*; ();

    logic [index_width-1:0]     rd_index;   // from the lane
    logic                       rd_valid;
    logic [cache_tag_width-1:0] rd_tag;
    logic [line_width-1:0]      rd_data;

    modport store (
        input  rd_index,
        output rd_valid,
        output rd_tag,
        output rd_data
    );

    modport lane (
        output rd_index,
        input  rd_valid,
        input  rd_tag,
        input  rd_data
    );

endinterface

// single fill port, miss controller into the line store
interface cache_fill_if import icache_pkg::*; ();

    logic                       wr_en;      // write on the rising clock
    logic [index_width-1:0]     wr_index;
    logic [cache_tag_width-1:0] wr_tag;
    logic [line_width-1:0]      wr_data;

    modport ctrl (
        output wr_en,
        output wr_index,
        output wr_tag,
        output wr_data
    );

    modport store (
        input  wr_en,
        input  wr_index,
        input  wr_tag,
        input  wr_data
    );

endinterface

// File: icache_pkg.sv
package icache_pkg;

    // fetch side
    parameter int lanes = 2;            // default lane count, top level overrides
    parameter int addr_width = 32;      // fetch and memory byte addresses

    // cache geometry, direct mapped
    parameter int line_count = 32;
    parameter int index_width = $clog2(line_count);    // address bits 7 to 3
    parameter int line_width = 64;                     // one instruction line

    // byte offset inside a line, always zero on the bus
    parameter int offset_width = $clog2(line_width / 8);

    // upper address bits above the tag are aliased
    parameter int cache_tag_width = 8;                 // address bits 15 to 8

    // memory bus
    parameter int mem_tag_width = 4;    // zero means no transaction

    // command encoding on the memory bus
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2    // part of the bus encoding, the cache never writes
    } bus_command_t;

endpackage
